//--- all.f
+incdir+hdl
+incdir+dv
hdl/rvc_pkg.sv
hdl/rvc_q0_expand.sv
hdl/rvc_q1_expand.sv
hdl/rvc_q2_expand.sv
hdl/rvc_expander_top.sv
dv/tb_rvc_expander.sv

//--- dv/rvc_ref_model.svh
`ifndef RVC_REF_MODEL_SVH
`define RVC_REF_MODEL_SVH

`include "rvc_config.svh"

// base formats of the rv32i spec
function automatic logic [31:0] itype_word(input logic [11:0] imm, input logic [4:0] rs1,
                                           input logic [2:0] f3, input logic [4:0] rd,
                                           input logic [6:0] opc);
    return {imm, rs1, f3, rd, opc};
endfunction

function automatic logic [31:0] stype_word(input logic [11:0] imm, input logic [4:0] rs2,
                                           input logic [4:0] rs1, input logic [2:0] f3,
                                           input logic [6:0] opc);
    return {imm[11:5], rs2, rs1, f3, imm[4:0], opc};
endfunction

function automatic logic [31:0] rtype_word(input logic [6:0] f7, input logic [4:0] rs2,
                                           input logic [4:0] rs1, input logic [2:0] f3,
                                           input logic [4:0] rd, input logic [6:0] opc);
    return {f7, rs2, rs1, f3, rd, opc};
endfunction

function automatic logic [31:0] utype_word(input logic [19:0] imm, input logic [4:0] rd,
                                           input logic [6:0] opc);
    return {imm, rd, opc};
endfunction

// x8 + index
function automatic logic [4:0] widen_creg(input logic [2:0] r);
    return 5'd8 + {2'b00, r};
endfunction

// expected rv32i word for one compressed instruction
function automatic logic [31:0] model_expand(input logic [15:0] c);
    logic [4:0]  rd;
    logic [4:0]  rs2;
    logic [4:0]  rdp;
    logic [4:0]  rs2p;
    logic [5:0]  imm6;
    logic [31:0] simm;
    logic [9:0]  off_4spn;
    logic [6:0]  off_w;
    logic [7:0]  off_lwsp;
    logic [7:0]  off_swsp;
    logic [9:0]  nzimm16;
    logic [31:0] s16;
    logic [31:0] word;
    rd   = c[11:7];
    rs2  = c[6:2];
    rdp  = widen_creg(c[9:7]);
    rs2p = widen_creg(c[4:2]);
    imm6 = {c[12], c[6:2]};
    simm = 32'($signed(imm6));
    // spec immediate scatter, bit by bit
    off_4spn = '0;
    off_4spn[5:4] = c[12:11];
    off_4spn[9:6] = c[10:7];
    off_4spn[2]   = c[6];
    off_4spn[3]   = c[5];
    off_w = '0;
    off_w[5:3] = c[12:10];
    off_w[2]   = c[6];
    off_w[6]   = c[5];
    off_lwsp = '0;
    off_lwsp[5]   = c[12];
    off_lwsp[4:2] = c[6:4];
    off_lwsp[7:6] = c[3:2];
    off_swsp = '0;
    off_swsp[5:2] = c[12:9];
    off_swsp[7:6] = c[8:7];
    nzimm16 = '0;
    nzimm16[9]   = c[12];
    nzimm16[4]   = c[6];
    nzimm16[6]   = c[5];
    nzimm16[8:7] = c[4:3];
    nzimm16[5]   = c[2];
    s16  = 32'($signed(nzimm16));
    word = `RVC_NOP_INST;
    if (c[1:0] == 2'b00) begin
        case (c[15:13])
            3'b000: word = itype_word({2'b00, off_4spn}, `RV_REG_SP, `RV_F3_ADD, rs2p,
                                      `RV_OPC_OP_IMM);
            3'b010: word = itype_word({5'b0, off_w}, rdp, `RV_F3_LW, rs2p, `RV_OPC_LOAD);
            3'b110: word = stype_word({5'b0, off_w}, rs2p, rdp, `RV_F3_LW, `RV_OPC_STORE);
            default: word = `RVC_NOP_INST;
        endcase
    end else if (c[1:0] == 2'b01) begin
        case (c[15:13])
            3'b000: word = itype_word(simm[11:0], rd, `RV_F3_ADD, rd, `RV_OPC_OP_IMM);
            3'b010: word = itype_word(simm[11:0], 5'd0, `RV_F3_ADD, rd, `RV_OPC_OP_IMM);
            3'b011: begin
                if (rd == 5'd2) begin
                    word = itype_word(s16[11:0], 5'd2, `RV_F3_ADD, 5'd2, `RV_OPC_OP_IMM);
                end else begin
                    word = utype_word(simm[19:0], rd, `RV_OPC_LUI);
                end
            end
            3'b100: begin
                case (c[11:10])
                    2'b00: word = itype_word({7'b0, c[6:2]}, rdp, `RV_F3_SR, rdp,
                                             `RV_OPC_OP_IMM);
                    2'b01: word = itype_word({`RV_F7_ALT, c[6:2]}, rdp, `RV_F3_SR, rdp,
                                             `RV_OPC_OP_IMM);
                    2'b10: word = itype_word(simm[11:0], rdp, `RV_F3_AND, rdp,
                                             `RV_OPC_OP_IMM);
                    default: begin
                        if (c[12]) begin
                            word = `RVC_NOP_INST;
                        end else if (c[6:5] == 2'b00) begin
                            word = rtype_word(`RV_F7_ALT, rs2p, rdp, `RV_F3_ADD, rdp, `RV_OPC_OP);
                        end else if (c[6:5] == 2'b01) begin
                            word = rtype_word(7'b0, rs2p, rdp, `RV_F3_XOR, rdp, `RV_OPC_OP);
                        end else if (c[6:5] == 2'b10) begin
                            word = rtype_word(7'b0, rs2p, rdp, `RV_F3_OR, rdp, `RV_OPC_OP);
                        end else begin
                            word = rtype_word(7'b0, rs2p, rdp, `RV_F3_AND, rdp, `RV_OPC_OP);
                        end
                    end
                endcase
            end
            default: word = `RVC_NOP_INST;  // jumps and branches
        endcase
    end else if (c[1:0] == 2'b10) begin
        case (c[15:13])
            3'b000: word = itype_word({7'b0, c[6:2]}, rd, `RV_F3_SLL, rd, `RV_OPC_OP_IMM);
            3'b010: word = itype_word({4'b0, off_lwsp}, `RV_REG_SP, `RV_F3_LW, rd,
                                      `RV_OPC_LOAD);
            3'b100: begin
                if (rs2 == 5'd0) begin
                    word = `RVC_NOP_INST;  // jr, jalr, ebreak
                end else if (!c[12]) begin
                    word = rtype_word(7'b0, rs2, 5'd0, `RV_F3_ADD, rd, `RV_OPC_OP);
                end else begin
                    word = rtype_word(7'b0, rs2, rd, `RV_F3_ADD, rd, `RV_OPC_OP);
                end
            end
            3'b110: word = stype_word({4'b0, off_swsp}, rs2, `RV_REG_SP, `RV_F3_LW,
                                      `RV_OPC_STORE);
            default: word = `RVC_NOP_INST;
        endcase
    end
    return word;
endfunction

`endif

//--- dv/tb_rvc_expander.sv
`timescale 1ns/1ps
`default_nettype none

module tb_rvc_expander;

    localparam int ACK_TIMEOUT = 20;  // cycles per handshake phase
    localparam int NUM_RANDOM  = 80;  // per quadrant

    logic               clk_i;
    logic               rst_n_i;
    logic               req_i;
    rvc_pkg::rvc_inst_t inst_i;
    logic               ack_o;
    rvc_pkg::rv_inst_t  expanded_o;
    rvc_pkg::rv_inst_t  exp_word;  // expected result of the transfer in flight

    `include "rvc_ref_model.svh"

    rvc_expander_top dut0 (
        .clk_i      (clk_i),
        .rst_n_i    (rst_n_i),
        .req_i      (req_i),
        .inst_i     (inst_i),
        .ack_o      (ack_o),
        .expanded_o (expanded_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #20 clk_i = ~clk_i;
    end

    task automatic abort_run();
        $display("Errors found");
        $fatal(1, "simulation stopped at first error");
    endtask

    // reset values, seen at the first edge out of reset
    reset_state: assert property (@(posedge clk_i) $rose(rst_n_i) |->
        (!ack_o && expanded_o == `RVC_NOP_INST))
    else begin
        $display("CHECK FAILED: after reset ack_o = %h expanded_o = %h, expected 0 and %h",
                 ack_o, expanded_o, `RVC_NOP_INST);
        abort_run();
    end

    data_match: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        ack_o |-> (expanded_o == exp_word))
    else begin
        $display("CHECK FAILED: expanded_o = %h, expected %h", expanded_o, exp_word);
        abort_run();
    end

    // ack two edges after the first edge that sees req high
    ack_latency: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        ($past(req_i, 2) && !$past(req_i, 3)) |-> $rose(ack_o))
    else begin
        $display("CHECK FAILED: ack_o = %h two edges after req_i rose, expected 1", ack_o);
        abort_run();
    end

    ack_early: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        $rose(ack_o) |-> ($past(req_i, 2) && !$past(req_i, 3)))
    else begin
        $display("CHECK FAILED: ack_o = %h rose at the wrong edge after req_i", ack_o);
        abort_run();
    end

    ack_needs_req: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        $rose(ack_o) |-> ($past(req_i) && req_i))
    else begin
        $display("CHECK FAILED: ack_o rose while req_i = %h", req_i);
        abort_run();
    end

    ack_held: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        ($past(ack_o) && $past(req_i)) |-> ack_o)
    else begin
        $display("CHECK FAILED: ack_o = %h while req_i held, expected 1", ack_o);
        abort_run();
    end

    result_held: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        ($past(ack_o) && $past(req_i)) |-> (expanded_o == $past(expanded_o)))
    else begin
        $display("CHECK FAILED: expanded_o = %h changed while held, expected %h",
                 expanded_o, exp_word);
        abort_run();
    end

    ack_release: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        ($past(ack_o) && !$past(req_i)) |-> !ack_o)
    else begin
        $display("CHECK FAILED: ack_o = %h one edge after req_i fell, expected 0", ack_o);
        abort_run();
    end

    // one four-phase transfer, entered and left on a rising edge
    task automatic run_transfer(input rvc_pkg::rvc_inst_t inst,
                                input rvc_pkg::rv_inst_t expected);
        int waited;
        int hold;
        hold = $urandom_range(4, 0);
        req_i    <= 1'b1;
        inst_i   <= inst;
        exp_word <= expected;
        waited = 0;
        @(posedge clk_i);
        while (!ack_o) begin
            if (waited == ACK_TIMEOUT) begin
                $display("timeout: ack_o stayed low for %0d cycles with req_i high",
                         ACK_TIMEOUT);
                abort_run();
            end
            waited++;
            @(posedge clk_i);
        end
        repeat (hold) @(posedge clk_i);  // back-pressure
        req_i  <= 1'b0;
        inst_i <= 16'($urandom);  // don't care while req is low
        waited = 0;
        @(posedge clk_i);
        while (ack_o) begin
            if (waited == ACK_TIMEOUT) begin
                $display("timeout: ack_o stayed high for %0d cycles with req_i low",
                         ACK_TIMEOUT);
                abort_run();
            end
            waited++;
            @(posedge clk_i);
        end
        repeat ($urandom_range(2, 0)) @(posedge clk_i);
    endtask

    initial begin
        rvc_pkg::rvc_inst_t c;
        void'($urandom(34373));
        rst_n_i  <= 1'b0;
        req_i    <= 1'b0;
        inst_i   <= '0;
        exp_word <= `RVC_NOP_INST;
        repeat (3) @(posedge clk_i);
        rst_n_i <= 1'b1;
        @(posedge clk_i);

        // quadrant 0, supported funct3 only
        for (int i = 0; i < NUM_RANDOM; i++) begin
            c = 16'($urandom);
            case (i % 3)
                0: c[15:13] = 3'b000;
                1: c[15:13] = 3'b010;
                default: c[15:13] = 3'b110;
            endcase
            c[1:0] = 2'b00;
            run_transfer(c, model_expand(c));
        end

        // quadrant 1
        for (int i = 0; i < NUM_RANDOM; i++) begin
            c = 16'($urandom);
            c[1:0] = 2'b01;
            if (i % 4 == 0) begin
                c[15:13] = 3'b011;  // c.addi16sp
                c[11:7]  = 5'd2;
            end else if (i % 4 == 1) begin
                c[15:13] = 3'b100;  // shifts and alu ops
            end
            run_transfer(c, model_expand(c));
        end

        // quadrant 2, extra weight on mv and add
        for (int i = 0; i < NUM_RANDOM; i++) begin
            c = 16'($urandom);
            c[1:0] = 2'b10;
            if (i % 3 == 0) begin
                c[15:13] = 3'b100;
            end
            run_transfer(c, model_expand(c));
        end

        // dropped encodings expand to the nop
        for (int i = 0; i < 45; i++) begin
            c = 16'($urandom);
            case (i % 9)
                0: c = {3'b101, c[12:2], 2'b01};          // c.j
                1: c = {3'b001, c[12:2], 2'b01};          // c.jal
                2: c = {3'b110, c[12:2], 2'b01};          // c.beqz
                3: c = {3'b111, c[12:2], 2'b01};          // c.bnez
                4: c = {4'b1000, c[11:7], 5'd0, 2'b10};   // c.jr
                5: c = {4'b1001, c[11:7], 5'd0, 2'b10};   // c.jalr
                6: c = 16'h9002;                          // c.ebreak
                7: c = {6'b100111, c[9:2], 2'b01};
                default: c[1:0] = 2'b11;                  // uncompressed
            endcase
            run_transfer(c, `RVC_NOP_INST);
        end

        $display("No errors");
        $finish;
    end

endmodule

`default_nettype wire

//--- hdl/rvc_config.svh
`ifndef RVC_CONFIG_SVH
`define RVC_CONFIG_SVH

// canonical nop, addi x0, x0, 0
`define RVC_NOP_INST      32'h0000_0013

// major opcodes
`define RV_OPC_OP_IMM     7'b0010011
`define RV_OPC_LOAD       7'b0000011
`define RV_OPC_STORE      7'b0100011
`define RV_OPC_OP         7'b0110011
`define RV_OPC_LUI        7'b0110111

// funct3 codes
`define RV_F3_ADD         3'b000  // add, sub, addi
`define RV_F3_SLL         3'b001
`define RV_F3_LW          3'b010  // lw and sw share it
`define RV_F3_XOR         3'b100
`define RV_F3_SR          3'b101  // srl, sra
`define RV_F3_OR          3'b110
`define RV_F3_AND         3'b111

// funct7 of sub and srai
`define RV_F7_ALT         7'b0100000

`define RV_REG_SP         5'd2

// x8..x15 from a 3-bit field
`define RVC_CREG_PREFIX   2'b01

`endif

//--- hdl/rvc_expander_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "rvc_config.svh"

module rvc_expander_top (
    input  wire                     clk_i,
    input  wire                     rst_n_i,
    input  wire                     req_i,
    input  wire rvc_pkg::rvc_inst_t inst_i,
    output logic                    ack_o,
    output rvc_pkg::rv_inst_t       expanded_o
);

    rvc_pkg::hs_state_t state_q;
    rvc_pkg::rvc_inst_t inst_q;      // captured request
    logic               capture_en;
    rvc_pkg::rv_inst_t  q0_inst;
    rvc_pkg::rv_inst_t  q1_inst;
    rvc_pkg::rv_inst_t  q2_inst;
    rvc_pkg::rv_inst_t  sel_inst;

    // first edge with req high while idle
    assign capture_en = (state_q == rvc_pkg::HS_IDLE) && req_i;

    always_ff @(posedge clk_i) begin
        if (capture_en) begin
            inst_q <= inst_i;
        end
    end

    rvc_q0_expand u_q0 (
        .inst_i (inst_q),
        .inst_o (q0_inst)
    );

    rvc_q1_expand u_q1 (
        .inst_i (inst_q),
        .inst_o (q1_inst)
    );

    rvc_q2_expand u_q2 (
        .inst_i (inst_q),
        .inst_o (q2_inst)
    );

    // quadrant by op bits
    always_comb begin
        case (inst_q[1:0])
            2'b00:   sel_inst = q0_inst;
            2'b01:   sel_inst = q1_inst;
            2'b10:   sel_inst = q2_inst;
            default: sel_inst = `RVC_NOP_INST;  // uncompressed word
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q    <= rvc_pkg::HS_IDLE;
            ack_o      <= 1'b0;
            expanded_o <= `RVC_NOP_INST;
        end else begin
            case (state_q)
                rvc_pkg::HS_IDLE: begin
                    if (req_i) begin
                        state_q <= rvc_pkg::HS_EXPAND;
                    end
                end
                rvc_pkg::HS_EXPAND: begin
                    expanded_o <= sel_inst;
                    ack_o      <= 1'b1;
                    state_q    <= rvc_pkg::HS_ACK;
                end
                rvc_pkg::HS_ACK: begin
                    // hold result until requester lets go
                    if (!req_i) begin
                        ack_o   <= 1'b0;
                        state_q <= rvc_pkg::HS_IDLE;
                    end
                end
                default: begin
                    ack_o   <= 1'b0;
                    state_q <= rvc_pkg::HS_IDLE;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

//--- hdl/rvc_pkg.sv
`default_nettype none

package rvc_pkg;

    // 16-bit compressed instruction
    typedef logic [15:0] rvc_inst_t;

    // 32-bit rv32i instruction
    typedef logic [31:0] rv_inst_t;

    typedef logic [4:0] reg_idx_t;   // x0..x31
    typedef logic [2:0] creg_idx_t;  // x8..x15, compressed form

    // four-phase req/ack handshake
    typedef enum logic [1:0] {
        HS_IDLE   = 2'd0,  // waiting for req
        HS_EXPAND = 2'd1,  // instruction captured
        HS_ACK    = 2'd2   // result valid, waiting for req low
    } hs_state_t;

endpackage

`default_nettype wire

//--- hdl/rvc_q0_expand.sv
`timescale 1ns/1ps
`default_nettype none

`include "rvc_config.svh"

module rvc_q0_expand (
    input  wire rvc_pkg::rvc_inst_t inst_i,
    output rvc_pkg::rv_inst_t       inst_o
);

    rvc_pkg::creg_idx_t rs1_c;  // rs1' of c.lw and c.sw
    rvc_pkg::creg_idx_t rd_c;   // rd' or rs2'
    rvc_pkg::reg_idx_t  rs1;
    rvc_pkg::reg_idx_t  rd;
    logic [11:0]        imm_4spn;
    logic [11:0]        imm_word;

    assign rs1_c = inst_i[9:7];
    assign rd_c  = inst_i[4:2];
    assign rs1   = {`RVC_CREG_PREFIX, rs1_c};
    assign rd    = {`RVC_CREG_PREFIX, rd_c};

    // nzuimm[5:4|9:6|2|3] at bits 12:5
    assign imm_4spn = {2'b00, inst_i[10:7], inst_i[12:11], inst_i[5], inst_i[6], 2'b00};

    // uimm[5:3] at 12:10, uimm[2] at 6, uimm[6] at 5
    assign imm_word = {5'b0, inst_i[5], inst_i[12:10], inst_i[6], 2'b00};

    always_comb begin
        inst_o = `RVC_NOP_INST;
        case (inst_i[15:13])
            3'b000: begin  // c.addi4spn
                inst_o = {imm_4spn, `RV_REG_SP, `RV_F3_ADD, rd, `RV_OPC_OP_IMM};
            end
            3'b010: begin  // c.lw
                inst_o = {imm_word, rs1, `RV_F3_LW, rd, `RV_OPC_LOAD};
            end
            3'b110: begin
                // c.sw with its offset split across imm[11:5] and imm[4:0]
                inst_o = {imm_word[11:5], rd, rs1, `RV_F3_LW, imm_word[4:0],
                          `RV_OPC_STORE};
            end
            default: begin
                inst_o = `RVC_NOP_INST;
            end
        endcase
    end

endmodule

`default_nettype wire

//--- hdl/rvc_q1_expand.sv
`timescale 1ns/1ps
`default_nettype none

`include "rvc_config.svh"

module rvc_q1_expand (
    input  wire rvc_pkg::rvc_inst_t inst_i,
    output rvc_pkg::rv_inst_t       inst_o
);

    rvc_pkg::reg_idx_t  rd;       // full rd for addi, li, lui
    rvc_pkg::creg_idx_t rd_c;
    rvc_pkg::creg_idx_t rs2_c;
    rvc_pkg::reg_idx_t  rd_p;     // widened rd'/rs1'
    rvc_pkg::reg_idx_t  rs2_p;
    logic [11:0]        imm_sext;
    logic [11:0]        imm_16sp;
    logic [4:0]         shamt;

    assign rd    = inst_i[11:7];
    assign rd_c  = inst_i[9:7];
    assign rs2_c = inst_i[4:2];
    assign rd_p  = {`RVC_CREG_PREFIX, rd_c};
    assign rs2_p = {`RVC_CREG_PREFIX, rs2_c};
    assign shamt = inst_i[6:2];

    // imm[5] at bit 12, imm[4:0] at 6:2
    assign imm_sext = {{7{inst_i[12]}}, inst_i[6:2]};

    // nzimm[9|4|6|8:7|5] at 12, 6:2
    assign imm_16sp = {{3{inst_i[12]}}, inst_i[4:3], inst_i[5], inst_i[2], inst_i[6], 4'b0000};

    always_comb begin
        inst_o = `RVC_NOP_INST;
        case (inst_i[15:13])
            3'b000: begin  // c.addi
                inst_o = {imm_sext, rd, `RV_F3_ADD, rd, `RV_OPC_OP_IMM};
            end
            3'b010: begin  // c.li
                inst_o = {imm_sext, 5'd0, `RV_F3_ADD, rd, `RV_OPC_OP_IMM};
            end
            3'b011: begin
                if (rd == `RV_REG_SP) begin
                    // c.addi16sp
                    inst_o = {imm_16sp, `RV_REG_SP, `RV_F3_ADD, `RV_REG_SP,
                              `RV_OPC_OP_IMM};
                end else begin
                    // c.lui, same 6-bit imm lands in [17:12]
                    inst_o = {{8{imm_sext[11]}}, imm_sext, rd, `RV_OPC_LUI};
                end
            end
            3'b100: begin
                case (inst_i[11:10])
                    2'b00: begin  // c.srli
                        inst_o = {7'b0, shamt, rd_p, `RV_F3_SR, rd_p, `RV_OPC_OP_IMM};
                    end
                    2'b01: begin  // c.srai
                        inst_o = {`RV_F7_ALT, shamt, rd_p, `RV_F3_SR, rd_p,
                                  `RV_OPC_OP_IMM};
                    end
                    2'b10: begin  // c.andi
                        inst_o = {imm_sext, rd_p, `RV_F3_AND, rd_p, `RV_OPC_OP_IMM};
                    end
                    default: begin
                        if (!inst_i[12]) begin
                            case (inst_i[6:5])
                                2'b00: inst_o = {`RV_F7_ALT, rs2_p, rd_p, `RV_F3_ADD, rd_p,
                                                 `RV_OPC_OP};  // c.sub
                                2'b01: inst_o = {7'b0, rs2_p, rd_p, `RV_F3_XOR, rd_p,
                                                 `RV_OPC_OP};  // c.xor
                                2'b10: inst_o = {7'b0, rs2_p, rd_p, `RV_F3_OR, rd_p,
                                                 `RV_OPC_OP};  // c.or
                                default: inst_o = {7'b0, rs2_p, rd_p, `RV_F3_AND, rd_p,
                                                   `RV_OPC_OP};  // c.and
                            endcase
                        end else begin
                            // rv64 subw/addw space
                            inst_o = `RVC_NOP_INST;
                        end
                    end
                endcase
            end
            default: begin
                // c.jal, c.j, c.beqz, c.bnez not supported
                inst_o = `RVC_NOP_INST;
            end
        endcase
    end

endmodule

`default_nettype wire

//--- hdl/rvc_q2_expand.sv
`timescale 1ns/1ps
`default_nettype none

`include "rvc_config.svh"

module rvc_q2_expand (
    input  wire rvc_pkg::rvc_inst_t inst_i,
    output rvc_pkg::rv_inst_t       inst_o
);

    rvc_pkg::reg_idx_t rd;   // rd or rs1
    rvc_pkg::reg_idx_t rs2;
    logic [11:0]       imm_lwsp;
    logic [11:0]       imm_swsp;

    assign rd  = inst_i[11:7];
    assign rs2 = inst_i[6:2];

    // uimm[5] at 12, uimm[4:2|7:6] at 6:2
    assign imm_lwsp = {4'b0, inst_i[3:2], inst_i[12], inst_i[6:4], 2'b00};

    // uimm[5:2|7:6] at 12:7
    assign imm_swsp = {4'b0, inst_i[8:7], inst_i[12:9], 2'b00};

    always_comb begin
        inst_o = `RVC_NOP_INST;
        case (inst_i[15:13])
            3'b000: begin  // c.slli, shamt in 6:2
                inst_o = {7'b0, rs2, rd, `RV_F3_SLL, rd, `RV_OPC_OP_IMM};
            end
            3'b010: begin  // c.lwsp
                inst_o = {imm_lwsp, `RV_REG_SP, `RV_F3_LW, rd, `RV_OPC_LOAD};
            end
            3'b100: begin
                if (rs2 == 5'd0) begin
                    // c.jr, c.jalr, c.ebreak
                    inst_o = `RVC_NOP_INST;
                end else if (!inst_i[12]) begin
                    // c.mv
                    inst_o = {7'b0, rs2, 5'd0, `RV_F3_ADD, rd, `RV_OPC_OP};
                end else begin
                    // c.add
                    inst_o = {7'b0, rs2, rd, `RV_F3_ADD, rd, `RV_OPC_OP};
                end
            end
            3'b110: begin  // c.swsp
                inst_o = {imm_swsp[11:5], rs2, `RV_REG_SP, `RV_F3_LW, imm_swsp[4:0],
                          `RV_OPC_STORE};
            end
            default: begin
                inst_o = `RVC_NOP_INST;
            end
        endcase
    end

endmodule

`default_nettype wire

//--- run.sh
#!/usr/bin/env bash
# build and run the rvc expander testbench with verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -j 0 --timescale 1ns/1ps \
    --top-module tb_rvc_expander -Mdir obj_dir -f all.f \
    && ./obj_dir/Vtb_rvc_expander 2>&1 | tee "$LOG" \
    || { echo "build or simulation failed"; exit 1; }

grep -q "^No errors$" "$LOG" && echo "PASS" || { echo "FAIL"; exit 1; }
